//--- hw/htif_cfg.svh
`ifndef HTIF_CFG_SVH
`define HTIF_CFG_SVH

// ---------------------------------------------------------------------------
// Widths and queue depth
// ---------------------------------------------------------------------------
`define HTIF_WORD_W      32
`define HTIF_BEAT_W      16
`define HTIF_ID_W        12
`define HTIF_ADDR_W      12
`define HTIF_FIFO_DEPTH  32

// Register indices, address bits 6:2
`define HTIF_REG_DCOUNT  5'd0   // Read: outbound level
`define HTIF_REG_RFIFO   5'd1   // Read: outbound head, pops
`define HTIF_REG_WFIFO   5'd0   // Write: inbound push
`define HTIF_REG_RESET   5'd31  // Write: cpu_reset pulse

`endif

//--- hw/htif_pkg.sv
`include "htif_cfg.svh"

package htif_pkg;

  typedef logic [`HTIF_WORD_W-1:0] htif_word_t;
  typedef logic [`HTIF_BEAT_W-1:0] host_beat_t;
  typedef logic [`HTIF_ID_W-1:0]   axi_id_t;
  typedef logic [`HTIF_ADDR_W-1:0] bus_addr_t;
  typedef logic [4:0]              reg_index_t;

  // One extra bit so a full queue fits
  typedef logic [$clog2(`HTIF_FIFO_DEPTH):0] fifo_level_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WRITE,
    WR_ACK
  } wr_state_t;

  typedef enum logic {
    RD_IDLE,
    RD_READ
  } rd_state_t;

endpackage

//--- hw/out_queue_if.sv
`timescale 1ns/1ns

// Outbound queue as seen from the register bridge
interface out_queue_if
  import htif_pkg::*;
();

  htif_word_t  head;   // Oldest packed word
  fifo_level_t level;  // Words held
  logic        avail;  // Head is valid
  logic        pop;    // Drop the head

  modport queue (
    output head, level, avail,
    input  pop
  );

  modport bridge (
    input  head, level, avail,
    output pop
  );

endinterface

//--- hw/htif_word_fifo.sv
`timescale 1ns/1ns
`include "htif_cfg.svh"

module htif_word_fifo
  import htif_pkg::*;
#(
  parameter int DEPTH = `HTIF_FIFO_DEPTH
)
(
  input  logic        userclk2,
  input  logic        reset,
  input  logic        wr_en,
  input  htif_word_t  din,
  input  logic        rd_en,
  output htif_word_t  dout,
  output logic        empty,
  output logic        full,
  output fifo_level_t level
);

  localparam int PTR_W = $clog2(DEPTH);

  htif_word_t       mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;

  assign dout  = mem[rd_ptr];  // Head visible without a read
  assign empty = (level == '0);
  assign full  = (level == fifo_level_t'(DEPTH));

  always_ff @(posedge userclk2)
  begin
    if (wr_en)
      mem[wr_ptr] <= din;
  end

  // ---------------------------------------------------------------------------
  // Pointers and level
  // ---------------------------------------------------------------------------
  always_ff @(posedge userclk2)
  begin
    if (reset)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      level  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;  // Wraps, DEPTH is a power of two
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;  // Idle or write and read together
      endcase
    end
  end

  // Both neighbours must watch full and empty
  a_no_overflow: assert property (@(posedge userclk2) disable iff (reset) wr_en |-> !full)
    else $error("htif_word_fifo: write while full");
  a_no_underflow: assert property (@(posedge userclk2) disable iff (reset) rd_en |-> !empty)
    else $error("htif_word_fifo: read while empty");

endmodule

//--- hw/host_in_path.sv
`timescale 1ns/1ns
`include "htif_cfg.svh"

module host_in_path
  import htif_pkg::*;
(
  input  logic       userclk2,
  input  logic       reset,
  input  logic       push,
  input  htif_word_t push_word,
  output logic       room,
  output logic       host_in_valid,
  input  logic       host_in_ready,
  output host_beat_t host_in_bits
);

  htif_word_t head;
  logic       empty;
  logic       full;
  logic       hi_half;    // Low half already sent
  logic       beat_xfer;

  htif_word_fifo in_fifo_i (
    .userclk2 (userclk2),
    .reset    (reset),
    .wr_en    (push),
    .din      (push_word),
    .rd_en    (beat_xfer && hi_half),  // Pop after the high half
    .dout     (head),
    .empty    (empty),
    .full     (full),
    .level    ()
  );

  assign room          = !full;
  assign host_in_valid = !empty;
  assign beat_xfer     = host_in_valid && host_in_ready;

  // Low half first, then high half
  assign host_in_bits = hi_half ? head[`HTIF_WORD_W-1:`HTIF_BEAT_W]
                                : head[`HTIF_BEAT_W-1:0];

  always_ff @(posedge userclk2)
  begin
    if (reset)
      hi_half <= 1'b0;
    else if (beat_xfer)
      hi_half <= !hi_half;
  end

endmodule

//--- hw/host_out_path.sv
`timescale 1ns/1ns

module host_out_path
  import htif_pkg::*;
(
  input  logic        userclk2,
  input  logic        reset,
  input  logic        host_out_valid,
  output logic        host_out_ready,
  input  host_beat_t  host_out_bits,
  out_queue_if.queue  q
);

  host_beat_t low_beat;   // First beat of the pair
  logic       have_low;
  logic       beat_xfer;
  logic       word_wr;
  logic       empty;
  logic       full;

  // A beat only counts on a real handshake
  assign host_out_ready = !full;
  assign beat_xfer      = host_out_valid && host_out_ready;
  assign word_wr        = beat_xfer && have_low;

  // ---------------------------------------------------------------------------
  // Beat pairing
  // ---------------------------------------------------------------------------
  always_ff @(posedge userclk2)
  begin
    if (beat_xfer && !have_low)
      low_beat <= host_out_bits;
  end

  always_ff @(posedge userclk2)
  begin
    if (reset)
      have_low <= 1'b0;
    else if (beat_xfer)
      have_low <= !have_low;
  end

  htif_word_fifo out_fifo_i (
    .userclk2 (userclk2),
    .reset    (reset),
    .wr_en    (word_wr),
    .din      ({host_out_bits, low_beat}),  // Second beat in the high half
    .rd_en    (q.pop),
    .dout     (q.head),
    .empty    (empty),
    .full     (full),
    .level    (q.level)
  );

  assign q.avail = !empty;

endmodule

//--- hw/htif_reg_bridge.sv
`timescale 1ns/1ns
`include "htif_cfg.svh"

module htif_reg_bridge
  import htif_pkg::*;
(
  input  logic        userclk2,
  input  logic        reset,
  // Write address
  input  logic        awvalid,
  output logic        awready,
  input  bus_addr_t   awaddr,
  input  axi_id_t     awid,
  // Write data
  input  logic        wvalid,
  output logic        wready,
  input  htif_word_t  wdata,
  // Write response
  output logic        bvalid,
  input  logic        bready,
  output axi_id_t     bid,
  // Read address
  input  logic        arvalid,
  output logic        arready,
  input  bus_addr_t   araddr,
  input  axi_id_t     arid,
  // Read data
  output logic        rvalid,
  input  logic        rready,
  output logic        rlast,
  output htif_word_t  rdata,
  output axi_id_t     rid,
  // Inbound queue
  output logic        push,
  output htif_word_t  push_word,
  input  logic        room,
  out_queue_if.bridge q,
  output logic        cpu_reset
);

  wr_state_t  wr_state;
  rd_state_t  rd_state;
  reg_index_t wr_index;
  reg_index_t rd_index;
  axi_id_t    wr_id;
  axi_id_t    rd_id;
  logic       do_write;

  // ---------------------------------------------------------------------------
  // Write side
  // ---------------------------------------------------------------------------
  // Index 0 holds off while the inbound queue is full
  assign do_write  = (wr_state == WR_WRITE) && ((wr_index != `HTIF_REG_WFIFO) || room);
  assign awready   = do_write;
  assign wready    = do_write;
  assign push      = do_write && (wr_index == `HTIF_REG_WFIFO);
  assign push_word = wdata;  // Still held, wready not yet given
  assign cpu_reset = do_write && (wr_index == `HTIF_REG_RESET);
  assign bvalid    = (wr_state == WR_ACK);
  assign bid       = wr_id;

  always_ff @(posedge userclk2)
  begin
    if (wr_state == WR_IDLE)
    begin
      wr_index <= awaddr[6:2];
      wr_id    <= awid;
    end
  end

  always_ff @(posedge userclk2)
  begin
    if (reset)
      wr_state <= WR_IDLE;
    else
      case (wr_state)
        WR_IDLE:  if (awvalid && wvalid) wr_state <= WR_WRITE;
        WR_WRITE: if (do_write) wr_state <= WR_ACK;
        WR_ACK:   if (bready) wr_state <= WR_IDLE;
        default:  wr_state <= WR_IDLE;
      endcase
  end

  // ---------------------------------------------------------------------------
  // Read side
  // ---------------------------------------------------------------------------
  assign arready = (rd_state == RD_IDLE);
  assign rvalid  = (rd_state == RD_READ);
  assign rlast   = rvalid;  // Single beat
  assign rid     = rd_id;
  assign rdata   = (rd_index == `HTIF_REG_DCOUNT) ? htif_word_t'(q.level) : q.head;
  assign q.pop   = rvalid && rready && (rd_index == `HTIF_REG_RFIFO) && q.avail;

  always_ff @(posedge userclk2)
  begin
    if (arready && arvalid)
    begin
      rd_index <= araddr[6:2];
      rd_id    <= arid;
    end
  end

  always_ff @(posedge userclk2)
  begin
    if (reset)
      rd_state <= RD_IDLE;
    else if (rd_state == RD_IDLE && arvalid)
      rd_state <= RD_READ;
    else if (rd_state == RD_READ && rready)
      rd_state <= RD_IDLE;
  end

  // Responses stay up until the master takes them
  a_bvalid_hold: assert property (@(posedge userclk2) disable iff (reset)
                                  bvalid && !bready |=> bvalid && (bid == $past(bid)))
    else $error("htif_reg_bridge: bvalid dropped before bready");
  a_rvalid_hold: assert property (@(posedge userclk2) disable iff (reset)
                                  rvalid && !rready |=> rvalid && (rid == $past(rid)))
    else $error("htif_reg_bridge: rvalid dropped before rready");

endmodule

//--- hw/htif_top.sv
`timescale 1ns/1ns

module htif_top
  import htif_pkg::*;
(
  input  logic       userclk2,
  input  logic       reset,
  input  logic       awvalid,
  output logic       awready,
  input  bus_addr_t  awaddr,
  input  axi_id_t    awid,
  input  logic       wvalid,
  output logic       wready,
  input  htif_word_t wdata,
  output logic       bvalid,
  input  logic       bready,
  output axi_id_t    bid,
  input  logic       arvalid,
  output logic       arready,
  input  bus_addr_t  araddr,
  input  axi_id_t    arid,
  output logic       rvalid,
  input  logic       rready,
  output logic       rlast,
  output htif_word_t rdata,
  output axi_id_t    rid,
  output logic       cpu_reset,
  // Host side
  output logic       host_in_valid,
  input  logic       host_in_ready,
  output host_beat_t host_in_bits,
  input  logic       host_out_valid,
  output logic       host_out_ready,
  input  host_beat_t host_out_bits
);

  logic       push;
  htif_word_t push_word;
  logic       room;

  out_queue_if out_q_i ();

  htif_reg_bridge reg_bridge_i (
    .userclk2 (userclk2), .reset (reset),
    .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .awid (awid),
    .wvalid (wvalid), .wready (wready), .wdata (wdata),
    .bvalid (bvalid), .bready (bready), .bid (bid),
    .arvalid (arvalid), .arready (arready), .araddr (araddr), .arid (arid),
    .rvalid (rvalid), .rready (rready), .rlast (rlast), .rdata (rdata), .rid (rid),
    .push (push), .push_word (push_word), .room (room),
    .q (out_q_i), .cpu_reset (cpu_reset)
  );

  // Bus writes to host
  host_in_path host_in_i (
    .userclk2 (userclk2), .reset (reset),
    .push (push), .push_word (push_word), .room (room),
    .host_in_valid (host_in_valid), .host_in_ready (host_in_ready),
    .host_in_bits (host_in_bits)
  );

  // Host to bus reads
  host_out_path host_out_i (
    .userclk2 (userclk2), .reset (reset),
    .host_out_valid (host_out_valid), .host_out_ready (host_out_ready),
    .host_out_bits (host_out_bits), .q (out_q_i)
  );

endmodule

//--- bench/htif_tb.sv
`timescale 1ns/1ns

module htif_tb;

  localparam int n_ent       = 4;
  localparam int sel_awready = 0;
  localparam int sel_bvalid  = 1;
  localparam int sel_arready = 2;
  localparam int sel_rvalid  = 3;
  localparam int sel_out_rdy = 4;
  localparam int sel_in_idle = 5;

  logic        userclk2, reset;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready, rlast, cpu_reset;
  logic [11:0] awaddr, awid, bid, araddr, arid, rid;
  logic [31:0] wdata, rdata;
  logic        host_in_valid, host_in_ready, host_out_valid, host_out_ready;
  logic [15:0] host_in_bits, host_out_bits;

  // Table columns are the bus word, its low beat, its high beat and the write ID
  logic [31:0] tab_word [n_ent] = '{32'h1234_5678, 32'hDEAD_BEEF, 32'h0000_FFFF, 32'h8001_7FFE};
  logic [15:0] tab_lo   [n_ent] = '{16'h5678, 16'hBEEF, 16'hFFFF, 16'h7FFE};
  logic [15:0] tab_hi   [n_ent] = '{16'h1234, 16'hDEAD, 16'h0000, 16'h8001};
  logic [11:0] tab_id   [n_ent] = '{12'h0A1, 12'h3C2, 12'hFFF, 12'h010};

  logic [15:0] got_beats [$];
  logic [15:0] exp_beats [$];
  logic [15:0] out_beats [$];
  logic [31:0] lcg_state = 32'd9303;
  logic [31:0] rd_val;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          err_mark;
  int          reset_pulses = 0;

  htif_top htif_top_i (.*);

  always #50 userclk2 = ~userclk2;

  // Host side monitor sampling each beat before the rising edge that moves it
  always @(negedge userclk2)
  begin
    if (!reset && host_in_valid && host_in_ready)
      got_beats.push_back(host_in_bits);
    if (!reset && cpu_reset)
      reset_pulses++;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic watched(input int sel);
    case (sel)
      sel_awready: return awready;
      sel_bvalid:  return bvalid;
      sel_arready: return arready;
      sel_rvalid:  return rvalid;
      sel_out_rdy: return host_out_ready;
      default:     return !host_in_valid;  // Inbound queue drained
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Something failed");
    $finish;
  endtask

  task automatic wait_high(input int sel, input string what, input int limit);
    int n;
    n = 0;
    @(negedge userclk2);
    while (!watched(sel) && n < limit)
    begin
      @(negedge userclk2);
      n++;
    end
    if (!watched(sel))
      abort_run({"Timed out waiting for ", what});
  endtask

  task automatic ack_gap();
    int gap;
    gap = int'((lcg_next() >> 16) & 32'd3);  // 0 to 3 idle cycles
    repeat (gap) @(posedge userclk2);
  endtask

  task automatic begin_write(input logic [11:0] addr, input logic [11:0] id,
                             input logic [31:0] data);
    @(posedge userclk2);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    awaddr  <= addr;
    awid    <= id;
    wdata   <= data;
  endtask

  task automatic complete_write(input logic [11:0] id);
    wait_high(sel_awready, "awready", 200);
    check_value("wready", 32'(wready), 32'd1);
    @(posedge userclk2);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    wait_high(sel_bvalid, "bvalid", 20);
    check_value("bid", 32'(bid), 32'(id));
    ack_gap();
    @(posedge userclk2);
    bready <= 1'b1;
    @(posedge userclk2);
    bready <= 1'b0;
  endtask

  task automatic bus_read(input logic [11:0] addr, input logic [11:0] id,
                          output logic [31:0] data);
    @(posedge userclk2);
    arvalid <= 1'b1;
    araddr  <= addr;
    arid    <= id;
    wait_high(sel_arready, "arready", 20);
    @(posedge userclk2);
    arvalid <= 1'b0;
    wait_high(sel_rvalid, "rvalid", 20);
    data = rdata;
    check_value("rid", 32'(rid), 32'(id));
    check_value("rlast", 32'(rlast), 32'd1);
    ack_gap();
    @(posedge userclk2);
    rready <= 1'b1;
    @(posedge userclk2);
    rready <= 1'b0;  // Pop for index 1 lands on this edge
  endtask

  task automatic push_beat(input logic [15:0] b);
    @(posedge userclk2);
    host_out_valid <= 1'b1;
    host_out_bits  <= b;
    wait_high(sel_out_rdy, "host_out_ready", 20);
    @(posedge userclk2);
    host_out_valid <= 1'b0;
  endtask

  task automatic check_beats();
    int k;
    check_value("beat count", 32'(got_beats.size()), 32'(exp_beats.size()));
    for (k = 0; k < exp_beats.size() && k < got_beats.size(); k++)
      check_value("host_in_bits", 32'(got_beats[k]), 32'(exp_beats[k]));
  endtask

  task automatic end_test(input int num, input string name);
    tests++;
    $display("test %0d %s: %0d errors", num, name, errors - err_mark);
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial
  begin
    int k;
    logic [31:0] word;
    userclk2 = 1'b0;
    reset = 1'b1;
    {awvalid, wvalid, bready, arvalid, rready, host_out_valid} = '0;
    {awaddr, awid, araddr, arid} = '0;
    wdata = '0;
    host_out_bits = '0;
    host_in_ready = 1'b1;
    repeat (10) @(posedge userclk2);
    reset <= 1'b0;

    err_mark = errors;
    @(negedge userclk2);
    check_value("arready", 32'(arready), 32'd1);
    check_value("host_out_ready", 32'(host_out_ready), 32'd1);
    check_value("awready", 32'(awready), 32'd0);
    check_value("wready", 32'(wready), 32'd0);
    check_value("bvalid", 32'(bvalid), 32'd0);
    check_value("rvalid", 32'(rvalid), 32'd0);
    check_value("rlast", 32'(rlast), 32'd0);
    check_value("host_in_valid", 32'(host_in_valid), 32'd0);
    check_value("cpu_reset", 32'(cpu_reset), 32'd0);
    end_test(1, "reset values");

    err_mark = errors;
    got_beats.delete();
    exp_beats.delete();
    for (k = 0; k < n_ent; k++)
    begin
      exp_beats.push_back(tab_lo[k]);
      exp_beats.push_back(tab_hi[k]);
      begin_write(12'h000, tab_id[k], tab_word[k]);
      complete_write(tab_id[k]);
    end
    wait_high(sel_in_idle, "inbound queue to drain", 100);
    check_beats();
    end_test(2, "inbound words");

    err_mark = errors;
    for (k = 0; k < n_ent; k++)
    begin
      push_beat(tab_lo[k]);
      push_beat(tab_hi[k]);
    end
    bus_read(12'h000, 12'h100, rd_val);  // Level register
    check_value("level", rd_val, 32'(n_ent));
    for (k = 0; k < n_ent; k++)
    begin
      bus_read(12'h004, tab_id[k] ^ 12'h5A5, rd_val);  // Head register pops the queue
      check_value("rdata", rd_val, tab_word[k]);
    end
    bus_read(12'h000, 12'h101, rd_val);
    check_value("level", rd_val, 32'd0);
    end_test(3, "outbound words");

    err_mark = errors;
    reset_pulses = 0;
    got_beats.delete();
    begin_write(12'h07C, 12'h777, 32'h0);  // Index 31
    complete_write(12'h777);
    @(negedge userclk2);
    check_value("cpu_reset pulses", 32'(reset_pulses), 32'd1);
    check_value("inbound beats", 32'(got_beats.size()), 32'd0);
    bus_read(12'h000, 12'h102, rd_val);
    check_value("level", rd_val, 32'd0);
    end_test(4, "cpu reset");

    err_mark = errors;
    @(posedge userclk2);
    host_in_ready <= 1'b0;
    got_beats.delete();
    exp_beats.delete();
    for (k = 0; k < 33; k++)
    begin
      word = lcg_next();
      exp_beats.push_back(word[15:0]);
      exp_beats.push_back(word[31:16]);
      begin_write(12'h000, 12'(k), word);
      if (k < 32)
        complete_write(12'(k));
    end
    for (k = 0; k < 50; k++)
    begin
      @(negedge userclk2);
      check_value("bvalid", 32'(bvalid), 32'd0);  // 33rd write must stall
      check_value("awready", 32'(awready), 32'd0);
    end
    @(posedge userclk2);
    host_in_ready <= 1'b1;
    complete_write(12'd32);
    wait_high(sel_in_idle, "inbound queue to drain", 200);
    check_beats();
    end_test(5, "inbound back-pressure");

    err_mark = errors;
    out_beats.delete();
    for (k = 0; k < 64; k++)
    begin
      out_beats.push_back(16'(lcg_next() >> 8));
      push_beat(out_beats[k]);
    end
    @(negedge userclk2);
    check_value("host_out_ready", 32'(host_out_ready), 32'd0);
    bus_read(12'h000, 12'h200, rd_val);
    check_value("level", rd_val, 32'd32);
    for (k = 0; k < 32; k++)
    begin
      bus_read(12'h004, 12'(k), rd_val);
      check_value("rdata", rd_val, {out_beats[2*k+1], out_beats[2*k]});
      if (k == 0)
      begin
        @(negedge userclk2);
        check_value("host_out_ready", 32'(host_out_ready), 32'd1);
      end
    end
    bus_read(12'h000, 12'h201, rd_val);
    check_value("level", rd_val, 32'd0);
    end_test(6, "outbound full");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- build.f
+incdir+hw
hw/htif_pkg.sv
hw/out_queue_if.sv
hw/htif_word_fifo.sv
hw/host_in_path.sv
hw/host_out_path.sv
hw/htif_reg_bridge.sv
hw/htif_top.sv
bench/htif_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it into sim.log, then look for the pass line
rm -f sim.log
verilator --binary --timing --assert --top-module htif_tb -f build.f -o htif_sim \
  && ./obj_dir/htif_sim > sim.log 2>&1 \
  || echo "Build or run stopped with an error"
cat sim.log 2>/dev/null
grep -q "Everything OK" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation did not pass"; exit 1; }
